// ==== filelist.f ====
+incdir+dv
design/alloc_pkg.sv
design/alloc_ram.sv
design/alloc_core.sv
design/alloc_selftest.sv
design/alloc_cmd_arb.sv
design/alloc_system.sv
dv/alloc_system_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the allocator testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module alloc_system_tb -o alloc_sim > build.log 2>&1 \
    && ./obj_dir/alloc_sim > sim.log 2>&1
grep -q "^RESULT: PASS$" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== dv/alloc_tb_host.svh ====
// ======================================================================
// host request tasks and the expected free-list and top pointer model
// ======================================================================
`ifndef ALLOC_TB_HOST_SVH
`define ALLOC_TB_HOST_SVH

// expected free list, front is the newest freed cell
logic [WORD_W-1:0] exp_free_q[$];
// expected next fresh cell
logic [WORD_W-1:0] exp_top;

// state left behind by two self-test runs
// second run walks its list from the top cell down, FIRST_CELL is freed last
task automatic model_after_selftest();
    exp_free_q.delete();
    for (int k = N + 1; k >= 2; k--) begin
        exp_free_q.push_front(WORD_W'(k));
    end
    exp_top = WORD_W'(N + 2);
endtask

function automatic logic addr_legal(logic [WORD_W-1:0] a);
    return (a >= FIRST_CELL) && (a < exp_top);
endfunction

// one host request, response must come exactly one cycle later
task automatic host_request(input alloc_op_e op, input logic [WORD_W-1:0] addr,
                            input logic [WORD_W-1:0] raddr,
                            input logic [WORD_W-1:0] data, output alloc_rsp_t rsp);
    int waited;
    @(posedge i_clk);
    i_host_req <= '{op: op, addr: addr, raddr: raddr, data: data};
    waited = 0;
    do begin
        @(posedge i_clk);
        i_host_req <= NOP_REQ;
        @(negedge i_clk);
        waited++;
    end while (!o_host_rsp.valid && waited < RSP_TIMEOUT);
    if (!o_host_rsp.valid) begin
        fail_run("host request got no response before the timeout");
    end
    check_value("host response latency", waited, 1);
    rsp = o_host_rsp;
endtask

// alloc with expected address and error from the model
task automatic host_alloc(input logic [WORD_W-1:0] data, output alloc_rsp_t rsp);
    logic              exp_err;
    logic [WORD_W-1:0] exp_addr;
    exp_err  = 1'b0;
    exp_addr = UNDEF;
    if (exp_free_q.size() > 0) begin
        // newest freed cell first
        exp_addr = exp_free_q.pop_front();
    end else if (exp_top < MEM_END) begin
        exp_addr = exp_top;
        exp_top  = exp_top + 1'b1;
    end else begin
        exp_err = 1'b1;
    end
    host_request(OP_ALLOC, UNDEF, UNDEF, data, rsp);
    check_value("o_host_rsp.err", rsp.err, exp_err);
    if (!exp_err) begin
        check_value("o_host_rsp.addr", rsp.addr, exp_addr);
    end
endtask

task automatic host_free(input logic [WORD_W-1:0] addr, output alloc_rsp_t rsp);
    logic exp_err;
    exp_err = !addr_legal(addr);
    if (!exp_err) begin
        exp_free_q.push_front(addr);
    end
    host_request(OP_FREE, addr, UNDEF, UNDEF, rsp);
    check_value("o_host_rsp.err", rsp.err, exp_err);
endtask

`endif

// ==== dv/alloc_system_tb.sv ====
// ======================================================================
// allocator system testbench: self-test under random pauses,
// then host free-list order, data path and error checks
// ======================================================================
module alloc_system_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import alloc_pkg::*;

    localparam int ADDR_W        = 8;
    localparam int TEST_LEN_LOG2 = 6;
    localparam int N             = 2 ** TEST_LEN_LOG2;
    // enabled edges until o_running falls
    localparam int LIMIT         = 8 * N + 1;
    localparam int TEST_TIMEOUT  = 20 * LIMIT;
    localparam int RSP_TIMEOUT   = 4;
    // cycle of the host read sent during the self-test
    localparam int PROBE_CYCLE   = 20;
    localparam logic [WORD_W-1:0] MEM_END = WORD_W'(2 ** ADDR_W);
    localparam alloc_req_t NOP_REQ = '{op: OP_NOP, addr: UNDEF, raddr: UNDEF, data: UNDEF};

    logic              i_clk;
    logic              i_rst_n;
    logic              i_en;
    alloc_req_t        i_host_req;
    alloc_rsp_t        o_host_rsp;
    logic              o_running;
    logic              o_passed;
    logic              o_error;
    logic [WORD_W-1:0] o_cells_freed;

    logic [16:0]       lfsr_q;
    int                fail_count;

    alloc_system u_dut (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_en         (i_en),
        .i_host_req   (i_host_req),
        .o_host_rsp   (o_host_rsp),
        .o_running    (o_running),
        .o_passed     (o_passed),
        .o_error      (o_error),
        .o_cells_freed(o_cells_freed)
    );

    initial i_clk = 1'b0;
    always #5 i_clk = ~i_clk;

    task automatic fail_run(input string msg);
        fail_count++;
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at time %0t: %s = %0h, expected %0h", $time, name, got, exp);
            fail_run("value check failed");
        end
    endtask

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    // one LFSR step per enable bit
    task automatic next_en_bit(output logic b);
        b      = lfsr_q[16];
        lfsr_q = lfsr_next(lfsr_q);
    endtask

    `include "alloc_tb_host.svh"

    initial begin
        logic              b;
        int                en_count;
        int                cycles;
        alloc_rsp_t        rsp;
        logic [WORD_W-1:0] spare;
        fail_count = 0;
        lfsr_q     = 17'd71750;
        i_rst_n    = 1'b0;
        i_en       = 1'b0;
        i_host_req = NOP_REQ;
        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b1;
        next_en_bit(b);
        i_en <= b;
        @(negedge i_clk);
        check_value("o_running", o_running, 1);
        check_value("o_passed", o_passed, 0);
        check_value("o_error", o_error, 0);
        check_value("o_host_rsp.valid", o_host_rsp.valid, 0);

        // self-test with random pauses and one rejected host read
        en_count = 0;
        cycles   = 0;
        while (en_count < LIMIT && cycles < TEST_TIMEOUT) begin
            @(posedge i_clk);
            cycles++;
            if (i_en) begin
                en_count++;
            end
            if (en_count >= LIMIT) begin
                i_en <= 1'b1;
            end else begin
                next_en_bit(b);
                i_en <= b;
            end
            i_host_req <= (cycles == PROBE_CYCLE) ?
                '{op: OP_READ, addr: FIRST_CELL, raddr: UNDEF, data: UNDEF} : NOP_REQ;
            @(negedge i_clk);
            check_value("o_running", o_running, en_count < LIMIT);
            if (cycles == PROBE_CYCLE + 1) begin
                check_value("o_host_rsp.valid", o_host_rsp.valid, 1);
                check_value("o_host_rsp.err", o_host_rsp.err, 1);
            end
        end
        if (en_count < LIMIT) begin
            fail_run("self-test did not finish before the timeout");
        end
        check_value("o_passed", o_passed, 1);
        check_value("o_error", o_error, 0);
        check_value("o_cells_freed", o_cells_freed, 2 * N);

        // free list comes back newest first, then the top pointer
        model_after_selftest();
        for (int k = 2; k <= N + 1; k++) begin
            host_alloc(WORD_W'(k) ^ 16'h5a00, rsp);
            check_value("alloc address", rsp.addr, k);
        end
        host_alloc(16'h0, rsp);
        check_value("alloc address", rsp.addr, N + 2);
        spare = rsp.addr;

        // write, read back, reverse swaps the word
        host_request(OP_WRITE, spare, UNDEF, 16'hbeef, rsp);
        check_value("o_host_rsp.err", rsp.err, 0);
        host_request(OP_READ, spare, UNDEF, UNDEF, rsp);
        check_value("o_host_rsp.rdata", rsp.rdata, 16'hbeef);
        host_request(OP_REVERSE, spare, spare, 16'h1234, rsp);
        check_value("o_host_rsp.rdata", rsp.rdata, 16'hbeef);
        host_request(OP_READ, spare, UNDEF, UNDEF, rsp);
        check_value("o_host_rsp.rdata", rsp.rdata, 16'h1234);
        // alloc initial value landed in the cell
        host_request(OP_READ, FIRST_CELL, UNDEF, UNDEF, rsp);
        check_value("o_host_rsp.rdata", rsp.rdata, 16'h5a02);

        // illegal requests, each followed by a legal one
        host_free(NIL, rsp);
        check_value("o_host_rsp.err", rsp.err, 1);
        host_request(OP_READ, FIRST_CELL, UNDEF, UNDEF, rsp);
        check_value("o_host_rsp.err", rsp.err, 0);
        host_request(OP_READ, exp_top, UNDEF, UNDEF, rsp);
        check_value("o_host_rsp.err", rsp.err, 1);
        host_request(OP_WRITE, FIRST_CELL, UNDEF, 16'h0042, rsp);
        check_value("o_host_rsp.err", rsp.err, 0);
        // use up every fresh cell
        while (exp_top < MEM_END) begin
            host_alloc(exp_top, rsp);
        end
        host_alloc(16'h0, rsp);
        check_value("o_host_rsp.err", rsp.err, 1);
        host_free(spare, rsp);
        check_value("o_host_rsp.err", rsp.err, 0);
        host_alloc(16'h0, rsp);
        check_value("alloc address", rsp.addr, spare);

        if (fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            fail_run("checks failed");
        end
    end

endmodule

// ==== design/alloc_system.sv ====
// ======================================================================
// allocator system: self-test, arbiter, core and cell memory
// ======================================================================
module alloc_system #(
    parameter int ADDR_W        = 8,
    parameter int TEST_LEN_LOG2 = 6
) (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_en,
    input  alloc_pkg::alloc_req_t        i_host_req,
    output alloc_pkg::alloc_rsp_t        o_host_rsp,
    output logic                         o_running,
    output logic                         o_passed,
    output logic                         o_error,
    output logic [alloc_pkg::WORD_W-1:0] o_cells_freed
);
    import alloc_pkg::*;

    alloc_req_t        test_req;
    alloc_req_t        core_req;
    alloc_rsp_t        core_rsp;
    alloc_rsp_t        test_rsp;
    logic              mem_we;
    logic [WORD_W-1:0] mem_waddr;
    logic [WORD_W-1:0] mem_wdata;
    logic [WORD_W-1:0] mem_raddr;
    logic [WORD_W-1:0] mem_fl_addr;
    logic [WORD_W-1:0] mem_rdata;
    logic [WORD_W-1:0] mem_fl_data;

    alloc_selftest #(
        .TEST_LEN_LOG2(TEST_LEN_LOG2)
    ) u_selftest (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_en         (i_en),
        .o_req        (test_req),
        .i_rsp        (test_rsp),
        .o_running    (o_running),
        .o_passed     (o_passed),
        .o_error      (o_error),
        .o_cells_freed(o_cells_freed)
    );

    alloc_cmd_arb u_arb (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_test_running(o_running),
        .i_test_req    (test_req),
        .i_host_req    (i_host_req),
        .o_core_req    (core_req),
        .i_core_rsp    (core_rsp),
        .o_test_rsp    (test_rsp),
        .o_host_rsp    (o_host_rsp)
    );

    alloc_core #(
        .ADDR_W(ADDR_W)
    ) u_core (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_req        (core_req),
        .o_rsp        (core_rsp),
        .o_mem_we     (mem_we),
        .o_mem_waddr  (mem_waddr),
        .o_mem_wdata  (mem_wdata),
        .o_mem_raddr  (mem_raddr),
        .o_mem_fl_addr(mem_fl_addr),
        .i_mem_rdata  (mem_rdata),
        .i_mem_fl_data(mem_fl_data)
    );

    alloc_ram #(
        .ADDR_W(ADDR_W)
    ) u_ram (
        .i_clk    (i_clk),
        .i_we     (mem_we),
        .i_waddr  (mem_waddr),
        .i_wdata  (mem_wdata),
        .i_raddr  (mem_raddr),
        .i_fl_addr(mem_fl_addr),
        .o_rdata  (mem_rdata),
        .o_fl_data(mem_fl_data)
    );

endmodule

// ==== design/alloc_cmd_arb.sv ====
// ======================================================================
// request arbiter: self-test owns the allocator while it runs,
// host requests are rejected until then, responses routed back
// ======================================================================
module alloc_cmd_arb (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_test_running,
    input  alloc_pkg::alloc_req_t i_test_req,
    input  alloc_pkg::alloc_req_t i_host_req,
    output alloc_pkg::alloc_req_t o_core_req,
    input  alloc_pkg::alloc_rsp_t i_core_rsp,
    output alloc_pkg::alloc_rsp_t o_test_rsp,
    output alloc_pkg::alloc_rsp_t o_host_rsp
);
    import alloc_pkg::*;

    // response in flight belongs to the self-test
    logic test_owns_q;
    // host request refused last cycle
    logic reject_q;

    // no added cycle on the request path
    assign o_core_req = i_test_running ? i_test_req : i_host_req;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            test_owns_q <= 1'b1;
            reject_q    <= 1'b0;
        end else begin
            test_owns_q <= i_test_running;
            reject_q    <= i_test_running && (i_host_req.op != OP_NOP);
        end
    end

    always_comb begin
        o_test_rsp       = i_core_rsp;
        o_test_rsp.valid = i_core_rsp.valid && test_owns_q;
        o_host_rsp       = i_core_rsp;
        o_host_rsp.valid = i_core_rsp.valid && !test_owns_q;
        // refused host request never reached the core
        if (reject_q) begin
            o_host_rsp = '{valid: 1'b1, err: 1'b1, addr: UNDEF, rdata: UNDEF};
        end
    end

endmodule

// ==== design/alloc_selftest.sv ====
// ======================================================================
// allocator self-test: two runs of build, reverse and tear-down,
// then reports pass, error and the number of freed cells
// ======================================================================
module alloc_selftest #(
    parameter int TEST_LEN_LOG2 = 6
) (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_en,
    output alloc_pkg::alloc_req_t        o_req,
    input  alloc_pkg::alloc_rsp_t        i_rsp,
    output logic                         o_running,
    output logic                         o_passed,
    output logic                         o_error,
    output logic [alloc_pkg::WORD_W-1:0] o_cells_freed
);
    import alloc_pkg::*;

    // counter value of the last cell in a phase
    localparam logic [TEST_LEN_LOG2-1:0] LAST_CELL = '1;
    // two runs of N frees
    localparam logic [WORD_W-1:0] FREE_TARGET = WORD_W'(2 * (2 ** TEST_LEN_LOG2));

    selftest_state_e          state_q;
    logic [TEST_LEN_LOG2-1:0] cnt_q;
    // second run
    logic                     run_q;
    // op issued last cycle, tags the response now arriving
    alloc_op_e                pend_op_q;

    // last alloc address, last link read, last cell worked on
    logic [WORD_W-1:0] addr_q;
    logic [WORD_W-1:0] rdata_q;
    logic [WORD_W-1:0] cur_q;

    logic              issue;
    logic              alloc_rsp;
    logic              rd_rsp;
    logic              free_rsp;
    logic [WORD_W-1:0] last_addr;
    logic [WORD_W-1:0] last_rdata;
    logic [WORD_W-1:0] freed_now;

    // response classes
    assign alloc_rsp = i_rsp.valid && (pend_op_q == OP_ALLOC);
    assign rd_rsp    = i_rsp.valid && ((pend_op_q == OP_READ) || (pend_op_q == OP_REVERSE));
    assign free_rsp  = i_rsp.valid && !i_rsp.err && (pend_op_q == OP_FREE);

    // newest value, arriving now or held from an earlier response
    assign last_addr  = alloc_rsp ? i_rsp.addr : addr_q;
    assign last_rdata = rd_rsp ? i_rsp.rdata : rdata_q;
    assign freed_now  = o_cells_freed + WORD_W'(free_rsp);

    // request for this cycle, nothing while paused
    always_comb begin
        o_req = '{op: OP_NOP, addr: UNDEF, raddr: UNDEF, data: UNDEF};
        if (i_en) begin
            case (state_q)
                ST_BUILD_ALLOC: begin
                    // each cell links to the one before, first to NIL
                    o_req.op   = OP_ALLOC;
                    o_req.data = (cnt_q == '0) ? NIL : last_addr;
                end
                ST_BUILD_REVERSE: begin
                    // start at the last alloc, then follow the old links
                    o_req.op    = OP_REVERSE;
                    o_req.addr  = (cnt_q == '0) ? last_addr : last_rdata;
                    o_req.raddr = o_req.addr;
                    o_req.data  = (cnt_q == '0) ? NIL : cur_q;
                end
                ST_TEAR_READ: begin
                    // new head is the last reversed cell
                    o_req.op   = OP_READ;
                    o_req.addr = (cnt_q == '0) ? cur_q : last_rdata;
                end
                ST_TEAR_FREE: begin
                    // cell read just before
                    o_req.op   = OP_FREE;
                    o_req.addr = cur_q;
                end
                default: begin
                    o_req.op = OP_NOP;
                end
            endcase
        end
    end

    assign issue = (o_req.op != OP_NOP);

    // response capture runs whether enabled or not
    always_ff @(posedge i_clk) begin
        if (alloc_rsp) begin
            addr_q <= i_rsp.addr;
        end
        if (rd_rsp) begin
            rdata_q <= i_rsp.rdata;
        end
        if (issue) begin
            cur_q <= o_req.addr;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q       <= ST_BUILD_ALLOC;
            cnt_q         <= '0;
            run_q         <= 1'b0;
            pend_op_q     <= OP_NOP;
            o_passed      <= 1'b0;
            o_error       <= 1'b0;
            o_cells_freed <= '0;
        end else begin
            pend_op_q <= o_req.op;
            if (free_rsp) begin
                o_cells_freed <= o_cells_freed + 1'b1;
            end
            if (i_rsp.valid && i_rsp.err) begin
                // halt on any allocator error
                state_q <= ST_DONE;
                o_error <= 1'b1;
            end else if (i_en) begin
                case (state_q)
                    ST_BUILD_ALLOC: begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cnt_q == LAST_CELL) begin
                            state_q <= ST_BUILD_REVERSE;
                        end
                    end
                    ST_BUILD_REVERSE: begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cnt_q == LAST_CELL) begin
                            state_q <= ST_TEAR_READ;
                        end
                    end
                    ST_TEAR_READ: begin
                        state_q <= ST_TEAR_FREE;
                    end
                    ST_TEAR_FREE: begin
                        // counter wraps to 0 at the end of the list
                        cnt_q   <= cnt_q + 1'b1;
                        state_q <= ST_TEAR_READ;
                        if (cnt_q == LAST_CELL) begin
                            run_q   <= 1'b1;
                            state_q <= run_q ? ST_CHECK : ST_BUILD_ALLOC;
                        end
                    end
                    ST_CHECK: begin
                        // list must end in NIL, every cell freed
                        o_passed <= (last_rdata == NIL) && (freed_now == FREE_TARGET);
                        state_q  <= ST_DONE;
                    end
                    default: begin
                        state_q <= ST_DONE;
                    end
                endcase
            end
        end
    end

    assign o_running = (state_q != ST_DONE);

endmodule

// ==== design/alloc_core.sv ====
// ======================================================================
// allocator core: top pointer, free-list head, cell writes and
// error detection, one request per cycle with a registered response
// ======================================================================
module alloc_core #(
    parameter int ADDR_W = 8
) (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  alloc_pkg::alloc_req_t        i_req,
    output alloc_pkg::alloc_rsp_t        o_rsp,
    output logic                         o_mem_we,
    output logic [alloc_pkg::WORD_W-1:0] o_mem_waddr,
    output logic [alloc_pkg::WORD_W-1:0] o_mem_wdata,
    output logic [alloc_pkg::WORD_W-1:0] o_mem_raddr,
    output logic [alloc_pkg::WORD_W-1:0] o_mem_fl_addr,
    input  logic [alloc_pkg::WORD_W-1:0] i_mem_rdata,
    input  logic [alloc_pkg::WORD_W-1:0] i_mem_fl_data
);
    import alloc_pkg::*;

    // one past the last cell
    localparam logic [WORD_W-1:0] MEM_END = WORD_W'(2 ** ADDR_W);

    // next fresh cell
    logic [WORD_W-1:0] top_q;
    logic [WORD_W-1:0] top_d;
    // newest freed cell, NIL when empty
    logic [WORD_W-1:0] head_q;
    logic [WORD_W-1:0] head_d;

    logic              rsp_valid_q;
    logic              rsp_err_q;
    logic [WORD_W-1:0] rsp_addr_q;

    logic              err;
    logic [WORD_W-1:0] new_addr;
    logic              addr_ok;
    logic              raddr_ok;

    // only cells handed out so far may be touched
    assign addr_ok  = (i_req.addr >= FIRST_CELL) && (i_req.addr < top_q);
    assign raddr_ok = (i_req.raddr >= FIRST_CELL) && (i_req.raddr < top_q);

    // opcode decode
    always_comb begin
        top_d       = top_q;
        head_d      = head_q;
        new_addr    = UNDEF;
        err         = 1'b0;
        o_mem_we    = 1'b0;
        o_mem_waddr = i_req.addr;
        o_mem_wdata = i_req.data;
        o_mem_raddr = UNDEF;
        case (i_req.op)
            OP_ALLOC: begin
                if (head_q != NIL) begin
                    // pop, successor comes from the async port
                    new_addr = head_q;
                    head_d   = i_mem_fl_data;
                end else if (top_q < MEM_END) begin
                    new_addr = top_q;
                    top_d    = top_q + 1'b1;
                end else begin
                    // free list and top both exhausted
                    err = 1'b1;
                end
                // initial value into the new cell
                o_mem_we    = !err;
                o_mem_waddr = new_addr;
            end
            OP_FREE: begin
                // push, cell links to old head
                err         = !addr_ok;
                o_mem_we    = addr_ok;
                o_mem_wdata = head_q;
                if (addr_ok) begin
                    head_d = i_req.addr;
                end
            end
            OP_READ: begin
                err         = !addr_ok;
                o_mem_raddr = i_req.addr;
            end
            OP_WRITE: begin
                err      = !addr_ok;
                o_mem_we = addr_ok;
            end
            OP_REVERSE: begin
                // write addr, read raddr, old word comes back
                err         = !(addr_ok && raddr_ok);
                o_mem_we    = addr_ok && raddr_ok;
                o_mem_raddr = i_req.raddr;
            end
            default: begin
                err = 1'b0;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            top_q       <= FIRST_CELL;
            head_q      <= NIL;
            rsp_valid_q <= 1'b0;
            rsp_err_q   <= 1'b0;
        end else begin
            top_q       <= top_d;
            head_q      <= head_d;
            rsp_valid_q <= (i_req.op != OP_NOP);
            rsp_err_q   <= err;
        end
    end

    always_ff @(posedge i_clk) begin
        rsp_addr_q <= new_addr;
    end

    assign o_mem_fl_addr = head_q;

    // rdata is already registered inside the ram
    assign o_rsp.valid = rsp_valid_q;
    assign o_rsp.err   = rsp_err_q;
    assign o_rsp.addr  = rsp_addr_q;
    assign o_rsp.rdata = i_mem_rdata;

endmodule

// ==== design/alloc_ram.sv ====
// ======================================================================
// allocator cell memory: one write port, one registered read port
// and one asynchronous port for the free-list successor
// ======================================================================
module alloc_ram #(
    parameter int ADDR_W = 8
) (
    input  logic                         i_clk,
    input  logic                         i_we,
    input  logic [alloc_pkg::WORD_W-1:0] i_waddr,
    input  logic [alloc_pkg::WORD_W-1:0] i_wdata,
    input  logic [alloc_pkg::WORD_W-1:0] i_raddr,
    input  logic [alloc_pkg::WORD_W-1:0] i_fl_addr,
    output logic [alloc_pkg::WORD_W-1:0] o_rdata,
    output logic [alloc_pkg::WORD_W-1:0] o_fl_data
);
    import alloc_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    // cell array
    logic [WORD_W-1:0] mem [DEPTH];
    // registered read data
    logic [WORD_W-1:0] rdata_q;

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr[ADDR_W-1:0]] <= i_wdata;
        end
        // same-address read returns the old word
        // reverse depends on this
        rdata_q <= mem[i_raddr[ADDR_W-1:0]];
    end

    assign o_rdata = rdata_q;

    // word stored in the free-list head = next head
    assign o_fl_data = mem[i_fl_addr[ADDR_W-1:0]];

endmodule

// ==== design/alloc_pkg.sv ====
// ======================================================================
// allocator shared types: word width, reserved addresses, opcodes,
// request and response structs, self-test states
// ======================================================================
package alloc_pkg;

    // width of a cell and of an address word
    localparam int WORD_W = 16;

    // reserved addresses
    // no value
    localparam logic [WORD_W-1:0] UNDEF = WORD_W'(0);
    // list terminator
    localparam logic [WORD_W-1:0] NIL = WORD_W'(1);
    // first cell handed out by the top pointer
    localparam logic [WORD_W-1:0] FIRST_CELL = WORD_W'(2);

    // request opcodes
    // reverse = read raddr and write addr in the same cycle
    typedef enum logic [2:0] {
        OP_NOP,
        OP_ALLOC,
        OP_FREE,
        OP_READ,
        OP_WRITE,
        OP_REVERSE
    } alloc_op_e;

    // one request per cycle
    typedef struct packed {
        alloc_op_e         op;
        // free / read / write address
        logic [WORD_W-1:0] addr;
        // read address of a reverse
        logic [WORD_W-1:0] raddr;
        // alloc initial value or write data
        logic [WORD_W-1:0] data;
    } alloc_req_t;

    // result, one cycle after the request
    typedef struct packed {
        logic              valid;
        logic              err;
        // allocated address
        logic [WORD_W-1:0] addr;
        logic [WORD_W-1:0] rdata;
    } alloc_rsp_t;

    // self-test sequencer states
    typedef enum logic [2:0] {
        ST_BUILD_ALLOC,
        ST_BUILD_REVERSE,
        ST_TEAR_READ,
        ST_TEAR_FREE,
        ST_CHECK,
        ST_DONE
    } selftest_state_e;

endpackage
